//--- rtl/core_types_pkg.sv
`default_nettype none

package core_types_pkg;

  // Integer register width of the RV32 core
  localparam int unsigned xlen = 32;

  // One register or memory data word
  typedef logic [xlen-1:0] rdata_t;

  // Register index, x0 to x31
  typedef logic [4:0] raddr_t;

  // Byte address as produced by the execute stage
  typedef logic [xlen-1:0] addr_t;

  // Result of the execute stage for one instruction
  // The write-enable stays low for stores and for an empty stage
  typedef struct packed {
    logic   we_rd;
    rdata_t result;
    raddr_t rd_addr;
  } s_ex_mem_wb_t;

  // Final write into the register file
  typedef struct packed {
    logic   we_rd;
    rdata_t rd_data;
    raddr_t rd_addr;
  } s_wb_t;

endpackage

`default_nettype wire

//--- rtl/lsu_types_pkg.sv
`default_nettype none

package lsu_types_pkg;

  // Kind of memory operation carried by an instruction
  typedef enum logic [1:0] {
    LSU_NONE,
    LSU_LOAD,
    LSU_STORE
  } lsu_op_typ_t;

  // Access width, the U variants zero-extend on loads
  typedef enum logic [2:0] {
    RV_LSU_B,
    RV_LSU_H,
    RV_LSU_W,
    RV_LSU_BU,
    RV_LSU_HU
  } lsu_width_t;

  // Memory part of one instruction
  typedef struct packed {
    lsu_op_typ_t          op_typ;
    lsu_width_t           width;
    core_types_pkg::addr_t  addr;
    core_types_pkg::rdata_t wdata;
  } s_lsu_op_t;

  // Request into the local data memory, addressed by words
  // Store data already sits on its byte lanes
  typedef struct packed {
    logic                                valid;
    logic                                we;
    logic [core_types_pkg::xlen-3:0]     waddr;
    core_types_pkg::rdata_t              wdata;
    logic [core_types_pkg::xlen/8-1:0]   strb;
  } s_mem_req_t;

endpackage

`default_nettype wire

//--- rtl/ex_mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

module ex_mem_stage (
  input  wire                           clk,
  input  wire                           rst_i,
  // From the execute stage
  input  wire                           in_valid_i,
  input  core_types_pkg::s_ex_mem_wb_t  in_exe_i,
  input  lsu_types_pkg::s_lsu_op_t      in_lsu_i,
  // Back-pressure from the load-store unit
  input  wire                           stall_i,
  // To the load-store unit and writeback
  output core_types_pkg::s_ex_mem_wb_t  exe_o,
  output lsu_types_pkg::s_lsu_op_t      lsu_o
);

  core_types_pkg::s_ex_mem_wb_t exe_ff;
  lsu_types_pkg::s_lsu_op_t     lsu_ff;

  // Only the write-enable and the operation kind mark the stage as full
  // The rest of the instruction is payload and is loaded as it comes
  always_ff @(posedge clk) begin
    if (rst_i) begin
      exe_ff.we_rd  <= 1'b0;
      lsu_ff.op_typ <= lsu_types_pkg::LSU_NONE;
    end else if (!stall_i) begin
      if (in_valid_i) begin
        exe_ff <= in_exe_i;
        lsu_ff <= in_lsu_i;
      end else begin
        // A bubble enters, nothing gets written and memory stays idle
        exe_ff.we_rd  <= 1'b0;
        lsu_ff.op_typ <= lsu_types_pkg::LSU_NONE;
      end
    end
    // While stalled the instruction stays put so that the memory access
    // and its register write see the same operands every cycle
  end

  assign exe_o = exe_ff;
  assign lsu_o = lsu_ff;

endmodule

`default_nettype wire

//--- rtl/lsu.sv
`timescale 1ns/100ps
`default_nettype none

module lsu #(
  parameter int unsigned mem_latency = 2
) (
  input  wire                           clk,
  input  wire                           rst_i,
  // Instruction currently in the stage register
  input  lsu_types_pkg::s_lsu_op_t      lsu_op_i,
  // Data memory side
  output lsu_types_pkg::s_mem_req_t     mem_req_o,
  input  wire                           mem_rvalid_i,
  input  core_types_pkg::rdata_t        mem_rdata_i,
  // To the stage register and writeback
  output logic                          bp_o,
  output logic                          bp_data_o,
  output core_types_pkg::rdata_t        rd_data_o
);

  // Counter wide enough to hold mem_latency - 1
  localparam int unsigned cnt_w = (mem_latency > 1) ? $clog2(mem_latency) : 1;

  typedef enum logic [1:0] {
    st_idle,
    st_wait,
    st_done
  } lsu_state_t;

  lsu_state_t             state_ff, next_state;
  logic [cnt_w-1:0]       cnt_ff, next_cnt;
  core_types_pkg::rdata_t rdata_ff;
  logic                   is_mem_op;
  logic                   is_load;

  assign is_mem_op = (lsu_op_i.op_typ != lsu_types_pkg::LSU_NONE);
  assign is_load   = (lsu_op_i.op_typ == lsu_types_pkg::LSU_LOAD);

  // Request is raised only in idle, so each instruction issues once even
  // though it stays in the stage register for the whole access
  always_comb begin
    mem_req_o.valid = (state_ff == st_idle) && is_mem_op;
    mem_req_o.we    = (lsu_op_i.op_typ == lsu_types_pkg::LSU_STORE);
    mem_req_o.waddr = lsu_op_i.addr[core_types_pkg::xlen-1:2];
    mem_req_o.wdata = lsu_op_i.wdata;
    mem_req_o.strb  = 4'b1111;
    case (lsu_op_i.width)
      lsu_types_pkg::RV_LSU_B, lsu_types_pkg::RV_LSU_BU: begin
        // Byte goes on all four lanes, the strobe picks one
        mem_req_o.wdata = {4{lsu_op_i.wdata[7:0]}};
        mem_req_o.strb  = 4'b0001 << lsu_op_i.addr[1:0];
      end
      lsu_types_pkg::RV_LSU_H, lsu_types_pkg::RV_LSU_HU: begin
        // Halfword offsets are 0 or 2; odd offsets are misaligned
        mem_req_o.wdata = {2{lsu_op_i.wdata[15:0]}};
        mem_req_o.strb  = 4'b0011 << {lsu_op_i.addr[1], 1'b0};
      end
      default: begin
        mem_req_o.strb = 4'b1111;
      end
    endcase
  end

  // FSM and latency counter
  always_comb begin
    next_state = state_ff;
    next_cnt   = cnt_ff;
    case (state_ff)
      st_idle: begin
        if (is_mem_op) begin
          next_state = st_wait;
          next_cnt   = cnt_w'(mem_latency - 1);
        end
      end
      st_wait: begin
        if (cnt_ff != '0) begin
          next_cnt = cnt_ff - 1'b1;
        end
        if (mem_rvalid_i) begin
          next_state = st_done;
        end
      end
      st_done: begin
        // Stage register releases the instruction at the end of this cycle
        next_state = st_idle;
      end
      default: begin
        next_state = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_ff <= st_idle;
      cnt_ff   <= '0;
    end else begin
      state_ff <= next_state;
      cnt_ff   <= next_cnt;
    end
  end

  // Returned word is kept so the data is still there in the done cycle
  always_ff @(posedge clk) begin
    if (mem_rvalid_i) begin
      rdata_ff <= mem_rdata_i;
    end
  end

  // Both levels come from registered state only, the memory pulse does not
  // reach the stall path; the counter knows when the word will arrive
  assign bp_o      = ((state_ff == st_idle) && is_mem_op) || (state_ff == st_wait);
  assign bp_data_o = is_load &&
                     (((state_ff == st_idle) && is_mem_op) ||
                      ((state_ff == st_wait) && (cnt_ff != '0)));

  // Live word in the response cycle, the held copy afterwards
  assign rd_data_o = mem_rvalid_i ? mem_rdata_i : rdata_ff;

endmodule

`default_nettype wire

//--- rtl/data_mem.sv
`timescale 1ns/100ps
`default_nettype none

module data_mem #(
  parameter int unsigned mem_latency = 2,
  parameter int unsigned mem_words   = 256
) (
  input  wire                           clk,
  input  wire                           rst_i,
  input  lsu_types_pkg::s_mem_req_t     req_i,
  output logic                          rvalid_o,
  output core_types_pkg::rdata_t        rdata_o
);

  localparam int unsigned idx_w = (mem_words > 1) ? $clog2(mem_words) : 1;

  core_types_pkg::rdata_t mem [mem_words];
  logic [idx_w-1:0]       idx;
  logic [mem_latency-1:0] valid_ff;
  core_types_pkg::rdata_t data_ff [mem_latency];

  // Upper word-address bits wrap around the array
  assign idx = req_i.waddr[idx_w-1:0];

  // Storage, cleared on reset, strobed writes land on the request cycle
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < mem_words; i++) begin
        mem[i] <= '0;
      end
    end else if (req_i.valid && req_i.we) begin
      for (int b = 0; b < core_types_pkg::xlen / 8; b++) begin
        if (req_i.strb[b]) begin
          mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Response pulse travels mem_latency stages, stores get an
  // acknowledge pulse the same way loads get their data
  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_ff <= '0;
    end else begin
      valid_ff[0] <= req_i.valid;
      for (int i = 1; i < mem_latency; i++) begin
        valid_ff[i] <= valid_ff[i-1];
      end
    end
  end

  // Read data follows the pulse, the word is read before any same-cycle write
  always_ff @(posedge clk) begin
    data_ff[0] <= mem[idx];
    for (int i = 1; i < mem_latency; i++) begin
      data_ff[i] <= data_ff[i-1];
    end
  end

  assign rvalid_o = valid_ff[mem_latency-1];
  assign rdata_o  = data_ff[mem_latency-1];

endmodule

`default_nettype wire

//--- rtl/wb.sv
`timescale 1ns/100ps
`default_nettype none

module wb (
  input  wire                           clk,
  input  wire                           rst_i,
  // From the stage register
  input  core_types_pkg::s_ex_mem_wb_t  ex_mem_wb_i,
  input  lsu_types_pkg::s_lsu_op_t      wb_lsu_i,
  // From the load-store unit
  input  core_types_pkg::rdata_t        lsu_rd_data_i,
  input  wire                           lsu_bp_i,
  input  wire                           lsu_bp_data_i,
  // To the register file and forwarding
  output core_types_pkg::s_wb_t         wb_dec_o,
  output core_types_pkg::rdata_t        wb_fwd_load_o,
  output logic                          lock_wb_o
);

  logic                   lock_wr_ff, next_lock;
  core_types_pkg::rdata_t bkp_load_ff, next_bkp;
  logic                   is_load;

  // Aligns the addressed bytes to bit 0 and extends them to a full word
  function automatic core_types_pkg::rdata_t fmt_load(
    lsu_types_pkg::s_lsu_op_t load,
    core_types_pkg::rdata_t   rdata
  );
    core_types_pkg::rdata_t data;
    data = rdata >> (8 * load.addr[1:0]);
    case (load.width)
      lsu_types_pkg::RV_LSU_B:  return {{24{data[7]}}, data[7:0]};
      lsu_types_pkg::RV_LSU_H:  return {{16{data[15]}}, data[15:0]};
      lsu_types_pkg::RV_LSU_BU: return {24'h0, data[7:0]};
      lsu_types_pkg::RV_LSU_HU: return {16'h0, data[15:0]};
      default:                  return data;
    endcase
  endfunction

  assign is_load = (wb_lsu_i.op_typ == lsu_types_pkg::LSU_LOAD);

  always_comb begin
    next_lock        = 1'b0;
    wb_dec_o.we_rd   = ex_mem_wb_i.we_rd;
    wb_dec_o.rd_data = ex_mem_wb_i.result;
    wb_dec_o.rd_addr = ex_mem_wb_i.rd_addr;
    // A store never touches a register
    if (wb_lsu_i.op_typ == lsu_types_pkg::LSU_STORE) begin
      wb_dec_o.we_rd = 1'b0;
    end
    if (is_load) begin
      // Completion cycle: stall still high but data no longer pending
      // Lock covers the single done cycle that follows it
      next_lock        = lsu_bp_i && !lsu_bp_data_i && !lock_wr_ff;
      // Write waits for the data and happens only once
      wb_dec_o.we_rd   = (lsu_bp_data_i || lock_wr_ff) ? 1'b0 : ex_mem_wb_i.we_rd;
      wb_dec_o.rd_data = fmt_load(wb_lsu_i, lsu_rd_data_i);
    end
  end

  // Last written value, offered to the front end for forwarding
  always_comb begin
    next_bkp = bkp_load_ff;
    if (wb_dec_o.we_rd) begin
      next_bkp = wb_dec_o.rd_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      lock_wr_ff  <= 1'b0;
      bkp_load_ff <= '0;
    end else begin
      lock_wr_ff  <= next_lock;
      bkp_load_ff <= next_bkp;
    end
  end

  assign lock_wb_o     = lock_wr_ff;
  assign wb_fwd_load_o = bkp_load_ff;

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  wire                           clk,
  input  wire                           rst_i,
  // Single write port from writeback
  input  core_types_pkg::s_wb_t         wr_i,
  // Debug read port
  input  core_types_pkg::raddr_t        raddr_i,
  output core_types_pkg::rdata_t        rdata_o
);

  core_types_pkg::rdata_t regs [32];

  // All registers start at zero, x0 is never written after that
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_i.we_rd && (wr_i.rd_addr != '0)) begin
      regs[wr_i.rd_addr] <= wr_i.rd_data;
    end
  end

  // Combinational read, x0 reads as zero in any case
  assign rdata_o = (raddr_i == '0) ? '0 : regs[raddr_i];

endmodule

`default_nettype wire

//--- rtl/lsu_wb_top.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_wb_top #(
  parameter int unsigned mem_latency = 2,
  parameter int unsigned mem_words   = 256
) (
  input  wire                           clk,
  input  wire                           rst_i,
  // Instruction from the execute stage
  input  wire                           in_valid_i,
  input  core_types_pkg::s_ex_mem_wb_t  in_exe_i,
  input  lsu_types_pkg::s_lsu_op_t      in_lsu_i,
  // Register file debug port
  input  core_types_pkg::raddr_t        rf_raddr_i,
  output logic                          stall_o,
  output core_types_pkg::rdata_t        rf_rdata_o,
  output core_types_pkg::rdata_t        fwd_data_o
);

  core_types_pkg::s_ex_mem_wb_t cur_exe;
  lsu_types_pkg::s_lsu_op_t     cur_lsu;
  lsu_types_pkg::s_mem_req_t    mem_req;
  logic                         mem_rvalid;
  core_types_pkg::rdata_t       mem_rdata;
  logic                         lsu_bp;
  logic                         lsu_bp_data;
  core_types_pkg::rdata_t       lsu_rdata;
  core_types_pkg::s_wb_t        wb_rf;
  logic                         lock_wb;

  ex_mem_stage i_ex_mem_stage (
    .clk        (clk),
    .rst_i      (rst_i),
    .in_valid_i (in_valid_i),
    .in_exe_i   (in_exe_i),
    .in_lsu_i   (in_lsu_i),
    .stall_i    (lsu_bp),
    .exe_o      (cur_exe),
    .lsu_o      (cur_lsu)
  );

  lsu #(
    .mem_latency (mem_latency)
  ) i_lsu (
    .clk          (clk),
    .rst_i        (rst_i),
    .lsu_op_i     (cur_lsu),
    .mem_req_o    (mem_req),
    .mem_rvalid_i (mem_rvalid),
    .mem_rdata_i  (mem_rdata),
    .bp_o         (lsu_bp),
    .bp_data_o    (lsu_bp_data),
    .rd_data_o    (lsu_rdata)
  );

  data_mem #(
    .mem_latency (mem_latency),
    .mem_words   (mem_words)
  ) i_data_mem (
    .clk      (clk),
    .rst_i    (rst_i),
    .req_i    (mem_req),
    .rvalid_o (mem_rvalid),
    .rdata_o  (mem_rdata)
  );

  wb i_wb (
    .clk           (clk),
    .rst_i         (rst_i),
    .ex_mem_wb_i   (cur_exe),
    .wb_lsu_i      (cur_lsu),
    .lsu_rd_data_i (lsu_rdata),
    .lsu_bp_i      (lsu_bp),
    .lsu_bp_data_i (lsu_bp_data),
    .wb_dec_o      (wb_rf),
    .wb_fwd_load_o (fwd_data_o),
    .lock_wb_o     (lock_wb)
  );

  reg_file i_reg_file (
    .clk     (clk),
    .rst_i   (rst_i),
    .wr_i    (wb_rf),
    .raddr_i (rf_raddr_i),
    .rdata_o (rf_rdata_o)
  );

  // Load-store back-pressure holds the source as well
  assign stall_o = lsu_bp;

endmodule

`default_nettype wire

//--- verification/lsu_wb_properties.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_wb_properties (
  input wire                      clk,
  input wire                      rst_i,
  input wire                      bp_i,
  input wire                      bp_data_i,
  input wire                      lock_i,
  input wire                      rvalid_i,
  input core_types_pkg::s_wb_t    wr_i,
  input lsu_types_pkg::s_lsu_op_t lsu_op_i
);

  logic        is_load;
  // Number of assertion failures seen so far
  int unsigned fail_cnt = 0;

  assign is_load = (lsu_op_i.op_typ == lsu_types_pkg::LSU_LOAD);

  // Lock is armed only by the completion cycle of a load
  lock_after_completion: assert property (
    @(posedge clk) disable iff (rst_i)
    lock_i |-> ($past(bp_i) && !$past(bp_data_i))
  ) else begin
    $error("Lock set without stall high and data pending low one cycle before");
    fail_cnt++;
  end

  // A locked cycle must not write the same load a second time
  no_write_under_lock: assert property (
    @(posedge clk) disable iff (rst_i)
    lock_i |-> !wr_i.we_rd
  ) else begin
    $error("Register write while the writeback lock is set");
    fail_cnt++;
  end

  // Load data reaches the register file only in the response cycle
  load_write_on_rvalid: assert property (
    @(posedge clk) disable iff (rst_i)
    (is_load && wr_i.we_rd) |-> rvalid_i
  ) else begin
    $error("Load written to the register file without a memory response");
    fail_cnt++;
  end

endmodule

// Hooked onto the wires where the writeback and the load-store unit meet
bind lsu_wb_top lsu_wb_properties i_lsu_wb_properties (
  .clk       (clk),
  .rst_i     (rst_i),
  .bp_i      (lsu_bp),
  .bp_data_i (lsu_bp_data),
  .lock_i    (lock_wb),
  .rvalid_i  (mem_rvalid),
  .wr_i      (wb_rf),
  .lsu_op_i  (cur_lsu)
);

`default_nettype wire

//--- verification/tb_lsu_wb.sv
`timescale 1ns/100ps
`default_nettype none

module tb_lsu_wb;

  localparam int unsigned mem_latency = 2;
  localparam int unsigned mem_words   = 256;
  localparam int unsigned n_directed  = 29;
  localparam int unsigned n_random    = 40;
  localparam int unsigned n_rows      = n_directed + n_random;
  localparam int unsigned cycle_limit = n_rows * (mem_latency + 4) + 100;

  localparam lsu_types_pkg::lsu_op_typ_t op_alu = lsu_types_pkg::LSU_NONE;
  localparam lsu_types_pkg::lsu_op_typ_t op_ld  = lsu_types_pkg::LSU_LOAD;
  localparam lsu_types_pkg::lsu_op_typ_t op_st  = lsu_types_pkg::LSU_STORE;
  localparam lsu_types_pkg::lsu_width_t  w_b    = lsu_types_pkg::RV_LSU_B;
  localparam lsu_types_pkg::lsu_width_t  w_h    = lsu_types_pkg::RV_LSU_H;
  localparam lsu_types_pkg::lsu_width_t  w_w    = lsu_types_pkg::RV_LSU_W;
  localparam lsu_types_pkg::lsu_width_t  w_bu   = lsu_types_pkg::RV_LSU_BU;
  localparam lsu_types_pkg::lsu_width_t  w_hu   = lsu_types_pkg::RV_LSU_HU;

  // One program step, data is the store data or the ALU result
  // exp and fwd hold the register value and forwarded value after the step
  typedef struct packed {
    logic [2:0]                 test_id;
    lsu_types_pkg::lsu_op_typ_t op;
    lsu_types_pkg::lsu_width_t  width;
    core_types_pkg::addr_t      addr;
    core_types_pkg::rdata_t     data;
    core_types_pkg::raddr_t     rd;
    core_types_pkg::rdata_t     exp;
    core_types_pkg::rdata_t     fwd;
  } row_t;

  logic                         clk;
  logic                         rst_i;
  logic                         in_valid_i;
  core_types_pkg::s_ex_mem_wb_t in_exe_i;
  lsu_types_pkg::s_lsu_op_t     in_lsu_i;
  core_types_pkg::raddr_t       rf_raddr_i;
  logic                         stall_o;
  core_types_pkg::rdata_t       rf_rdata_o;
  core_types_pkg::rdata_t       fwd_data_o;

  row_t                   rows [n_rows];
  core_types_pkg::rdata_t model_mem [mem_words];
  core_types_pkg::rdata_t model_regs [32];
  core_types_pkg::rdata_t model_fwd;
  int unsigned            n_added   = 0;
  int unsigned            cycles    = 0;
  int unsigned            err_cnt   = 0;
  int unsigned            err_base  = 0;
  int unsigned            test_rows = 0;
  int unsigned            tests_run = 0;
  int unsigned            checks    = 0;
  int                     seed;

  lsu_wb_top #(
    .mem_latency (mem_latency),
    .mem_words   (mem_words)
  ) i_dut (
    .clk        (clk),
    .rst_i      (rst_i),
    .in_valid_i (in_valid_i),
    .in_exe_i   (in_exe_i),
    .in_lsu_i   (in_lsu_i),
    .rf_raddr_i (rf_raddr_i),
    .stall_o    (stall_o),
    .rf_rdata_o (rf_rdata_o),
    .fwd_data_o (fwd_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // The limit allows every row the full memory round trip plus slack
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, stall_o was never released", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // Model memory, each stored byte lands at its own byte offset
  task automatic store_bytes(input lsu_types_pkg::lsu_width_t width,
                             input core_types_pkg::addr_t addr,
                             input core_types_pkg::rdata_t data);
    int unsigned nbytes;
    int unsigned idx;
    nbytes = (width == w_b || width == w_bu) ? 1 : (width == w_h || width == w_hu) ? 2 : 4;
    idx    = (addr >> 2) % mem_words;
    for (int b = 0; b < nbytes; b++) begin
      model_mem[idx][8 * (addr[1:0] + b) +: 8] = data[8 * b +: 8];
    end
  endtask

  function automatic core_types_pkg::rdata_t load_value(input lsu_types_pkg::lsu_width_t width,
                                                        input core_types_pkg::addr_t addr);
    core_types_pkg::rdata_t word;
    int                     value;
    word = model_mem[(addr >> 2) % mem_words] >> (8 * addr[1:0]);
    case (width)
      w_b:     value = $signed(word[7:0]);
      w_h:     value = $signed(word[15:0]);
      w_bu:    value = word & 32'h0000_00ff;
      w_hu:    value = word & 32'h0000_ffff;
      default: value = word;
    endcase
    return value;
  endfunction

  // Appends a row and moves the reference state past it
  task automatic add_row(input int test_id, input lsu_types_pkg::lsu_op_typ_t op,
                         input lsu_types_pkg::lsu_width_t width, input core_types_pkg::addr_t addr,
                         input core_types_pkg::rdata_t data, input core_types_pkg::raddr_t rd,
                         input core_types_pkg::rdata_t exp);
    row_t r;
    r = '0;
    r.test_id = test_id;
    r.op      = op;
    r.width   = width;
    r.addr    = addr;
    r.data    = data;
    r.rd      = (op == op_st) ? '0 : rd;
    r.exp     = exp;
    if (op == op_st) begin
      store_bytes(width, addr, data);
    end else begin
      // Every ALU or load write updates the forwarded value, x0 included
      model_fwd = (op == op_ld) ? load_value(width, addr) : data;
      if (rd != 0) begin
        model_regs[rd] = model_fwd;
      end
    end
    r.fwd = model_fwd;
    rows[n_added] = r;
    n_added++;
  endtask

  task automatic drive_row(input row_t r, input logic valid);
    in_valid_i       = valid;
    in_exe_i.we_rd   = valid && (r.op != op_st);
    in_exe_i.result  = r.data;
    in_exe_i.rd_addr = r.rd;
    in_lsu_i.op_typ  = r.op;
    in_lsu_i.width   = r.width;
    in_lsu_i.addr    = r.addr;
    in_lsu_i.wdata   = r.data;
  endtask

  function automatic string test_name(input int id);
    case (id)
      1:       return "ALU writes back to back";
      2:       return "word store and load";
      3:       return "byte and halfword loads";
      4:       return "single write per load";
      default: return "random mixed stream";
    endcase
  endfunction

  // Register file and forwarding value right after the row has retired
  task automatic check_row(input int unsigned idx);
    row_t r;
    logic last;
    r = rows[idx];
    if (r.op != op_st && rf_rdata_o !== r.exp) begin
      $display("Fail at time %0t: rf_rdata_o (x%0d, row %0d) expected %h, actual %h",
               $time, r.rd, idx, r.exp, rf_rdata_o);
      err_cnt++;
    end
    if (fwd_data_o !== r.fwd) begin
      $display("Fail at time %0t: fwd_data_o (row %0d) expected %h, actual %h",
               $time, idx, r.fwd, fwd_data_o);
      err_cnt++;
    end
    checks++;
    test_rows++;
    last = 1'b1;
    if (idx + 1 < n_rows) begin
      last = (rows[idx + 1].test_id != r.test_id);
    end
    if (last) begin
      $display("Test %0d %s: %0d rows, %0d errors", r.test_id, test_name(r.test_id),
               test_rows, err_cnt - err_base);
      err_base  = err_cnt;
      test_rows = 0;
      tests_run++;
    end
  endtask

  initial begin
    lsu_types_pkg::lsu_op_typ_t op;
    lsu_types_pkg::lsu_width_t  width;
    core_types_pkg::addr_t      addr;
    core_types_pkg::rdata_t     data;
    core_types_pkg::raddr_t     rd;
    core_types_pkg::rdata_t     exp;
    seed       = 32'h848a48ee;
    rst_i      = 1'b1;
    in_valid_i = 1'b0;
    in_exe_i   = '0;
    in_lsu_i   = '0;
    rf_raddr_i = '0;
    model_fwd  = '0;
    for (int i = 0; i < mem_words; i++) begin
      model_mem[i] = '0;
    end
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end

    // test, kind, width, address, data or ALU result, rd, expected rd value
    add_row(1, op_alu, w_w, 0, 32'h1111_0001, 1, 32'h1111_0001);
    add_row(1, op_alu, w_w, 0, 32'h8000_0002, 2, 32'h8000_0002);
    add_row(1, op_alu, w_w, 0, 32'hdead_beef, 0, 32'h0000_0000);
    add_row(1, op_alu, w_w, 0, 32'h0000_0033, 3, 32'h0000_0033);
    add_row(2, op_st, w_w, 32'h10, 32'hcafe_f00d, 0, 0);
    add_row(2, op_ld, w_w, 32'h10, 0, 4, 32'hcafe_f00d);
    add_row(3, op_st, w_b, 32'h20, 32'h0000_0080, 0, 0);
    add_row(3, op_st, w_b, 32'h21, 32'h0000_007f, 0, 0);
    add_row(3, op_st, w_b, 32'h22, 32'h0000_00a5, 0, 0);
    add_row(3, op_st, w_b, 32'h23, 32'h0000_003c, 0, 0);
    add_row(3, op_ld, w_b, 32'h20, 0, 5, 32'hffff_ff80);
    add_row(3, op_ld, w_bu, 32'h20, 0, 6, 32'h0000_0080);
    add_row(3, op_ld, w_b, 32'h21, 0, 7, 32'h0000_007f);
    add_row(3, op_ld, w_b, 32'h22, 0, 8, 32'hffff_ffa5);
    add_row(3, op_ld, w_bu, 32'h23, 0, 9, 32'h0000_003c);
    add_row(3, op_ld, w_h, 32'h20, 0, 10, 32'h0000_7f80);
    add_row(3, op_ld, w_hu, 32'h22, 0, 11, 32'h0000_3ca5);
    add_row(3, op_st, w_h, 32'h30, 32'h1234_8001, 0, 0);
    add_row(3, op_st, w_h, 32'h32, 32'h0000_f00f, 0, 0);
    add_row(3, op_ld, w_h, 32'h30, 0, 12, 32'hffff_8001);
    add_row(3, op_ld, w_hu, 32'h30, 0, 13, 32'h0000_8001);
    add_row(3, op_ld, w_h, 32'h32, 0, 14, 32'hffff_f00f);
    add_row(3, op_ld, w_bu, 32'h21, 0, 16, 32'h0000_007f);
    add_row(3, op_ld, w_bu, 32'h22, 0, 17, 32'h0000_00a5);
    add_row(3, op_ld, w_b, 32'h23, 0, 18, 32'h0000_003c);
    // Marker first, the load must replace it exactly once
    add_row(4, op_alu, w_w, 0, 32'h5a5a_5a5a, 21, 32'h5a5a_5a5a);
    add_row(4, op_ld, w_w, 32'h20, 0, 21, 32'h3ca5_7f80);
    add_row(4, op_alu, w_w, 0, 32'ha5a5_a5a5, 22, 32'ha5a5_a5a5);
    add_row(4, op_ld, w_b, 32'h33, 0, 22, 32'hffff_fff0);

    // Random rows stay inside the first 64 words so loads hit stored data
    for (int i = 0; i < n_random; i++) begin
      op    = lsu_types_pkg::lsu_op_typ_t'($unsigned($random(seed)) % 3);
      width = lsu_types_pkg::lsu_width_t'($unsigned($random(seed)) % 5);
      addr  = (($unsigned($random(seed)) % 64) << 2) | ($unsigned($random(seed)) % 4);
      if (width == w_w) begin
        addr[1:0] = 2'b00;
      end else if (width == w_h || width == w_hu) begin
        addr[0] = 1'b0;
      end
      data = $random(seed);
      rd   = $unsigned($random(seed)) % 32;
      exp  = (op == op_ld) ? load_value(width, addr) : data;
      if (rd == 0) begin
        exp = '0;
      end
      add_row(5, op, width, addr, data, rd, exp);
    end

    repeat (5) @(posedge clk);
    #1;
    rst_i = 1'b0;

    // Row k is driven while row k-1 sits in the stage, row k-2 has retired
    for (int k = 0; k < n_rows + 2; k++) begin
      if (k < n_rows) begin
        drive_row(rows[k], 1'b1);
      end else begin
        drive_row('0, 1'b0);
      end
      rf_raddr_i = '0;
      if (k >= 2) begin
        rf_raddr_i = rows[k - 2].rd;
      end
      @(negedge clk);
      if (k >= 1 && k <= n_rows) begin
        if (rows[k - 1].op == op_alu && stall_o) begin
          $display("Fail at time %0t: stall_o (row %0d) expected 0, actual 1", $time, k - 1);
          err_cnt++;
        end
      end
      if (k >= 2) begin
        check_row(k - 2);
      end
      while (stall_o) begin
        @(negedge clk);
      end
      @(posedge clk);
      #1;
    end

    // Whole register file against the model after the program
    for (int r = 0; r < 32; r++) begin
      rf_raddr_i = r;
      @(negedge clk);
      if (rf_rdata_o !== model_regs[r]) begin
        $display("Fail at time %0t: rf_rdata_o (x%0d) expected %h, actual %h",
                 $time, r, model_regs[r], rf_rdata_o);
        err_cnt++;
      end
      checks++;
      @(posedge clk);
      #1;
    end
    $display("Test 6 final register file: 32 registers, %0d errors", err_cnt - err_base);
    tests_run++;

    // Bound assertions on the lock and write signals count as errors too
    if (i_dut.i_lsu_wb_properties.fail_cnt != 0) begin
      $display("Bound assertions on stall, lock and write failed %0d times",
               i_dut.i_lsu_wb_properties.fail_cnt);
      err_cnt += i_dut.i_lsu_wb_properties.fail_cnt;
    end

    $display("Done: %0d tests, %0d checks, %0d errors", tests_run, checks, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
rtl/core_types_pkg.sv
rtl/lsu_types_pkg.sv
rtl/ex_mem_stage.sv
rtl/lsu.sv
rtl/data_mem.sv
rtl/wb.sv
rtl/reg_file.sv
rtl/lsu_wb_top.sv
verification/lsu_wb_properties.sv
verification/tb_lsu_wb.sv

//--- Bender.yml
package:
  name: lsu_wb

sources:
  - rtl/core_types_pkg.sv
  - rtl/lsu_types_pkg.sv
  - rtl/ex_mem_stage.sv
  - rtl/lsu.sv
  - rtl/data_mem.sv
  - rtl/wb.sv
  - rtl/reg_file.sv
  - rtl/lsu_wb_top.sv
  - target: simulation
    files:
      - verification/lsu_wb_properties.sv
      - verification/tb_lsu_wb.sv
